/* compile.f */
design/riscv_pkg.sv
design/riscv_hazard_if.sv
design/riscv_pipe_reg.sv
design/riscv_fetch.sv
design/riscv_decode.sv
design/riscv_execute.sv
design/riscv_hazard.sv
design/riscv_core.sv
verif/riscv_core_properties.sv
verif/riscv_core_tb.sv

/* design/riscv_core.sv */
`timescale 1ns/10ps

module riscv_core import riscv_pkg::*; (
  input  logic  i_riscv_core_clk,
  input  logic  i_rst_n,
  output data_t o_imem_addr,
  input  inst_t i_imem_data,    // combinational read of o_imem_addr
  output data_t o_dmem_addr,
  output data_t o_dmem_wdata,
  output logic  o_dmem_we,
  input  data_t i_dmem_rdata    // combinational read of o_dmem_addr
);

  data_t pc_f;
  logic  redirect;
  data_t target;
  data_t wb_data;
  fd_t   fd_d;
  fd_t   fd_q;
  de_t   de_d;
  de_t   de_q;
  em_t   em_d;
  em_t   em_q;
  mw_t   mw_d;
  mw_t   mw_q;

  riscv_hazard_if hz_if ();

  riscv_fetch u_riscv_fetch (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .hz               (hz_if.fetch),
    .i_redirect       (redirect),
    .i_target         (target),
    .o_pc             (pc_f)
  );

  assign o_imem_addr = pc_f;
  assign fd_d        = '{pc: pc_f, inst: i_imem_data};

  riscv_pipe_reg #(.payload_t(fd_t)) u_fd_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_en             (~hz_if.stall_d),
    .i_flush          (hz_if.flush_d),
    .i_d              (fd_d),
    .o_q              (fd_q)
  );

  riscv_decode u_riscv_decode (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_fd             (fd_q),
    .i_mw             (mw_q),
    .hz               (hz_if.decode),
    .o_de             (de_d),
    .o_wb_data        (wb_data)
  );

  riscv_pipe_reg #(.payload_t(de_t)) u_de_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_en             (1'b1),
    .i_flush          (hz_if.flush_e),
    .i_d              (de_d),
    .o_q              (de_q)
  );

  riscv_execute u_riscv_execute (
    .i_de             (de_q),
    .i_wb_data        (wb_data),
    .i_m_result       (em_q.alu_res),   // loads never forward from here
    .hz               (hz_if.execute),
    .o_em             (em_d),
    .o_redirect       (redirect),
    .o_target         (target)
  );

  riscv_pipe_reg #(.payload_t(em_t)) u_em_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_en             (1'b1),
    .i_flush          (1'b0),
    .i_d              (em_d),
    .o_q              (em_q)
  );

  // memory stage is just the data port
  assign o_dmem_addr  = em_q.alu_res;
  assign o_dmem_wdata = em_q.store_data;
  assign o_dmem_we    = em_q.mem_write;

  assign mw_d = '{
    alu_res:   em_q.alu_res,
    load_data: i_dmem_rdata,
    pc4:       em_q.pc4,
    rd:        em_q.rd,
    reg_write: em_q.reg_write,
    res_src:   em_q.res_src
  };

  riscv_pipe_reg #(.payload_t(mw_t)) u_mw_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_en             (1'b1),
    .i_flush          (1'b0),
    .i_d              (mw_d),
    .o_q              (mw_q)
  );

  assign hz_if.rd_m   = em_q.rd;
  assign hz_if.regw_m = em_q.reg_write;
  assign hz_if.rd_w   = mw_q.rd;
  assign hz_if.regw_w = mw_q.reg_write;

  riscv_hazard u_riscv_hazard (
    .hz (hz_if.hazard)
  );

endmodule

/* design/riscv_decode.sv */
`timescale 1ns/10ps

module riscv_decode import riscv_pkg::*; (
  input  logic           i_riscv_core_clk,
  input  logic           i_rst_n,
  input  fd_t            i_fd,
  input  mw_t            i_mw,        // writeback payload
  riscv_hazard_if.decode hz,
  output de_t            o_de,
  output data_t          o_wb_data    // also feeds forwarding
);

  inst_t      inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  logic       use_rs1;
  logic       use_rs2;
  ctrl_t      ctrl;
  data_t      imm;
  data_t      regs [2**REG_AW];

  assign inst     = i_fd.inst;
  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7_5 = inst[30];

  // unused source fields read as x0 so they never match a hazard
  assign rs1 = use_rs1 ? inst[19:15] : '0;
  assign rs2 = use_rs2 ? inst[24:20] : '0;

  always_comb begin
    ctrl    = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b111:  ctrl.alu_op = ALU_AND;
          default: ctrl.reg_write = 1'b0;   // not in the subset
        endcase
      end
      OPC_OPIMM: begin                      // addi only
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        use_rs1        = 1'b1;
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.res_src   = RES_LOAD;
        use_rs1        = 1'b1;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.res_src   = RES_PC4;           // link
      end
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      OPC_STORE:  imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      OPC_BRANCH: imm = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                         inst[11:8], 1'b0};
      OPC_JAL:    imm = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                         inst[30:21], 1'b0};
      OPC_LUI:    imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      default:    imm = {{(XLEN-12){inst[31]}}, inst[31:20]};   // I type
    endcase
  end

  always_comb begin
    case (i_mw.res_src)
      RES_LOAD: o_wb_data = i_mw.load_data;
      RES_PC4:  o_wb_data = i_mw.pc4;
      default:  o_wb_data = i_mw.alu_res;
    endcase
  end

  // falling edge write, so the read later in the same cycle sees it
  always_ff @(negedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_mw.reg_write && i_mw.rd != '0) begin
      regs[i_mw.rd] <= o_wb_data;
    end
  end

  assign hz.rs1_d = rs1;
  assign hz.rs2_d = rs2;

  assign o_de = '{
    pc:      i_fd.pc,
    rs1:     rs1,
    rs2:     rs2,
    rs1_val: (rs1 == '0) ? '0 : regs[rs1],
    rs2_val: (rs2 == '0) ? '0 : regs[rs2],
    rd:      inst[11:7],
    imm:     imm,
    ctrl:    ctrl
  };

endmodule

/* design/riscv_execute.sv */
`timescale 1ns/10ps

module riscv_execute import riscv_pkg::*; (
  input  de_t             i_de,
  input  data_t           i_wb_data,    // writeback result
  input  data_t           i_m_result,   // memory stage alu result
  riscv_hazard_if.execute hz,
  output em_t             o_em,
  output logic            o_redirect,
  output data_t           o_target
);

  data_t src_a;
  data_t src_b_reg;
  data_t src_b;
  data_t alu_res;
  logic  equal;
  logic  taken;

  function automatic data_t fwd_mux(fwd_sel_t sel, data_t reg_val, data_t m_val,
                                    data_t w_val);
    case (sel)
      FWD_MEM: return m_val;
      FWD_WB:  return w_val;
      default: return reg_val;
    endcase
  endfunction

  assign src_a     = fwd_mux(hz.fwd_a, i_de.rs1_val, i_m_result, i_wb_data);
  assign src_b_reg = fwd_mux(hz.fwd_b, i_de.rs2_val, i_m_result, i_wb_data);
  assign src_b     = i_de.ctrl.use_imm ? i_de.imm : src_b_reg;

  always_comb begin
    case (i_de.ctrl.alu_op)
      ALU_SUB:    alu_res = src_a - src_b;
      ALU_AND:    alu_res = src_a & src_b;
      ALU_OR:     alu_res = src_a | src_b;
      ALU_XOR:    alu_res = src_a ^ src_b;
      ALU_PASS_B: alu_res = src_b;
      default:    alu_res = src_a + src_b;   // add and address calc
    endcase
  end

  // compare uses the forwarded register, never the immediate
  assign equal = (src_a == src_b_reg);
  assign taken = i_de.ctrl.jump | (i_de.ctrl.branch & (equal ^ i_de.ctrl.branch_ne));

  assign o_redirect = taken;
  assign o_target   = i_de.pc + i_de.imm;   // branch and jal alike

  assign hz.rs1_e      = i_de.rs1;
  assign hz.rs2_e      = i_de.rs2;
  assign hz.rd_e       = i_de.rd;
  assign hz.load_e     = i_de.ctrl.mem_read;
  assign hz.redirect_e = taken;

  assign o_em = '{
    alu_res:    alu_res,
    store_data: src_b_reg,
    pc4:        i_de.pc + XLEN'(4),
    rd:         i_de.rd,
    reg_write:  i_de.ctrl.reg_write,
    mem_write:  i_de.ctrl.mem_write,
    res_src:    i_de.ctrl.res_src
  };

endmodule

/* design/riscv_fetch.sv */
`timescale 1ns/10ps

module riscv_fetch import riscv_pkg::*; (
  input  logic          i_riscv_core_clk,
  input  logic          i_rst_n,
  riscv_hazard_if.fetch hz,
  input  logic          i_redirect,   // taken branch or jal from execute
  input  data_t         i_target,
  output data_t         o_pc
);

  data_t pc_next;

  // redirect first, then stall, then sequential
  always_comb begin
    if (i_redirect) begin
      pc_next = i_target;
    end else if (hz.stall_f) begin
      pc_next = o_pc;             // load-use bubble
    end else begin
      pc_next = o_pc + XLEN'(4);
    end
  end

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc <= RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

endmodule

/* design/riscv_hazard.sv */
`timescale 1ns/10ps

module riscv_hazard import riscv_pkg::*; (
  riscv_hazard_if.hazard hz
);

  logic lw_stall;

  // nearest producer wins, x0 never forwards
  function automatic fwd_sel_t fwd_pick(reg_addr_t rs, reg_addr_t rd_m, logic regw_m,
                                        reg_addr_t rd_w, logic regw_w);
    if (rs != '0 && regw_m && rd_m == rs) begin
      return FWD_MEM;
    end else if (rs != '0 && regw_w && rd_w == rs) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  assign hz.fwd_a = fwd_pick(hz.rs1_e, hz.rd_m, hz.regw_m, hz.rd_w, hz.regw_w);
  assign hz.fwd_b = fwd_pick(hz.rs2_e, hz.rd_m, hz.regw_m, hz.rd_w, hz.regw_w);

  // load result only exists after memory, consumer in decode waits one cycle
  assign lw_stall = hz.load_e && (hz.rd_e != '0) &&
                    ((hz.rd_e == hz.rs1_d) || (hz.rd_e == hz.rs2_d));

  // a redirect squashes the stalled pair anyway, so it overrides the stall
  assign hz.stall_f = lw_stall & ~hz.redirect_e;
  assign hz.stall_d = lw_stall & ~hz.redirect_e;
  assign hz.flush_d = hz.redirect_e;
  assign hz.flush_e = hz.redirect_e | lw_stall;   // bubble into execute

endmodule

/* design/riscv_hazard_if.sv */
`timescale 1ns/10ps

interface riscv_hazard_if import riscv_pkg::*; ();

  reg_addr_t rs1_d;
  reg_addr_t rs2_d;
  reg_addr_t rs1_e;
  reg_addr_t rs2_e;
  reg_addr_t rd_e;
  logic      load_e;       // load sitting in execute
  logic      redirect_e;   // taken branch or jal in execute
  reg_addr_t rd_m;
  logic      regw_m;
  reg_addr_t rd_w;
  logic      regw_w;

  logic      stall_f;
  logic      stall_d;
  logic      flush_d;
  logic      flush_e;
  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;

  modport fetch (input stall_f);

  modport decode (output rs1_d, rs2_d);

  modport execute (
    output rs1_e, rs2_e, rd_e, load_e, redirect_e,
    input  fwd_a, fwd_b
  );

  modport hazard (
    input  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e, redirect_e,
    input  rd_m, regw_m, rd_w, regw_w,
    output stall_f, stall_d, flush_d, flush_e, fwd_a, fwd_b
  );

endinterface

/* design/riscv_pipe_reg.sv */
`timescale 1ns/10ps

module riscv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_riscv_core_clk,
  input  logic     i_rst_n,
  input  logic     i_en,        // low holds the stage
  input  logic     i_flush,     // loads a bubble
  input  payload_t i_d,
  output payload_t o_q
);

  // an all-zero payload has every control bit cleared, i.e. a bubble
  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_q <= '0;
    end else if (i_flush) begin
      o_q <= '0;                // flush beats a held stage
    end else if (i_en) begin
      o_q <= i_d;
    end
  end

endmodule

/* design/riscv_pkg.sv */
package riscv_pkg;

  localparam int XLEN   = 64;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   data_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [31:0]       inst_t;

  localparam data_t RESET_PC = '0;

  // base opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef enum logic [2:0] {
    ALU_ADD,                  // zero value, so a bubble decodes as add
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B                // lui
  } alu_op_t;

  typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4} res_src_t;

  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_write;
    logic     mem_read;
    logic     branch;
    logic     branch_ne;      // bne when set, beq otherwise
    logic     jump;
    logic     use_imm;        // operand b from immediate
    alu_op_t  alu_op;
    res_src_t res_src;
  } ctrl_t;

  typedef struct packed {
    data_t pc;
    inst_t inst;
  } fd_t;

  typedef struct packed {
    data_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     rs1_val;
    data_t     rs2_val;
    reg_addr_t rd;
    data_t     imm;
    ctrl_t     ctrl;
  } de_t;

  typedef struct packed {
    data_t     alu_res;
    data_t     store_data;
    data_t     pc4;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_write;
    res_src_t  res_src;
  } em_t;

  typedef struct packed {
    data_t     alu_res;
    data_t     load_data;
    data_t     pc4;
    reg_addr_t rd;
    logic      reg_write;
    res_src_t  res_src;
  } mw_t;

endpackage

/* verif/riscv_core_properties.sv */
`timescale 1ns/10ps

module riscv_core_properties import riscv_pkg::*; (
  input logic  i_riscv_core_clk,
  input logic  i_rst_n,
  input data_t i_imem_addr,
  input data_t i_dmem_addr,
  input logic  i_dmem_we,
  input logic  i_redirect,
  input logic  i_stall_f,
  input data_t i_poison_addr   // skipped stores point here
);

  int unsigned fail_cnt = 0;   // read by the testbench at the end

  we_low_in_reset: assert property (@(posedge i_riscv_core_clk) !i_rst_n |-> !i_dmem_we)
    else begin
      $error("store enable high while reset is held");
      fail_cnt++;
    end

  // first fetch after reset release
  first_fetch: assert property (@(posedge i_riscv_core_clk)
    $rose(i_rst_n) |-> i_imem_addr == RESET_PC)
    else begin
      $error("first fetch address is not the reset pc");
      fail_cnt++;
    end

  seq_fetch: assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    !i_redirect && !i_stall_f |=> i_imem_addr == $past(i_imem_addr) + 64'd4)
    else begin
      $error("fetch address did not advance by 4");
      fail_cnt++;
    end

  no_poison_store: assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    i_dmem_we |-> i_dmem_addr != i_poison_addr)
    else begin
      $error("squashed store reached the data port");
      fail_cnt++;
    end

  // the two slots behind a taken branch or jal reach memory as bubbles
  squash_after_redirect: assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    i_redirect |=> ##1 !i_dmem_we [*2])
    else begin
      $error("an instruction behind a redirect wrote data memory");
      fail_cnt++;
    end

endmodule

bind riscv_core riscv_core_properties u_riscv_core_properties (
  .i_riscv_core_clk (i_riscv_core_clk),
  .i_rst_n          (i_rst_n),
  .i_imem_addr      (o_imem_addr),
  .i_dmem_addr      (o_dmem_addr),
  .i_dmem_we        (o_dmem_we),
  .i_redirect       (redirect),
  .i_stall_f        (hz_if.stall_f),
  .i_poison_addr    (64'h7f0)
);

/* verif/riscv_core_tb.sv */
`timescale 1ns/10ps

module riscv_core_tb import riscv_pkg::*; ();

  logic        clk;
  logic        rst_n;
  data_t       imem_addr;
  inst_t       imem_data;
  data_t       dmem_addr;
  data_t       dmem_wdata;
  logic        dmem_we;
  data_t       dmem_rdata;
  inst_t       imem [256];
  data_t       dmem [256];
  data_t       xr [32];                   // reference register file
  data_t       ref_mem [data_t];
  data_t       exp_addr_q [$];
  data_t       exp_data_q [$];
  data_t       poison_addr = 64'h7f0;
  data_t       marker_addr = 64'h7f8;     // last store of the program
  logic [31:0] lfsr = 32'h8d74cf13;
  int          slot;                      // next instruction index
  int          errors;
  int          stores;
  int          cycles;
  logic        done;

  riscv_core i_riscv_core (
    .i_riscv_core_clk (clk),
    .i_rst_n          (rst_n),
    .o_imem_addr      (imem_addr),
    .i_imem_data      (imem_data),
    .o_dmem_addr      (dmem_addr),
    .o_dmem_wdata     (dmem_wdata),
    .o_dmem_we        (dmem_we),
    .i_dmem_rdata     (dmem_rdata)
  );

  // single-cycle memories indexed by word
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[10:3]];

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[10:3]] <= dmem_wdata;
    end
  end

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic data_t sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  task automatic place(inst_t w);
    imem[slot] = w;
    slot++;
  endtask

  task automatic set_reg(int rd, data_t v);
    if (rd != 0) begin
      xr[rd] = v;
    end
  endtask

  // kind 0 add, 1 sub, 2 and, 3 or, 4 xor
  task automatic alu_rr(int kind, int rd, int rs1, int rs2);
    logic [2:0] f3;
    data_t      v;
    f3 = (kind == 2) ? 3'b111 : (kind == 3) ? 3'b110 : (kind == 4) ? 3'b100 : 3'b000;
    case (kind)
      1:       v = xr[rs1] - xr[rs2];
      2:       v = xr[rs1] & xr[rs2];
      3:       v = xr[rs1] | xr[rs2];
      4:       v = xr[rs1] ^ xr[rs2];
      default: v = xr[rs1] + xr[rs2];
    endcase
    place({1'b0, (kind == 1), 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP});
    set_reg(rd, v);
  endtask

  task automatic add_imm(int rd, int rs1, logic [11:0] imm);
    place({imm, 5'(rs1), 3'b000, 5'(rd), OPC_OPIMM});
    set_reg(rd, xr[rs1] + sext12(imm));
  endtask

  task automatic load_upper(int rd, logic [19:0] imm);
    place({imm, 5'(rd), OPC_LUI});
    set_reg(rd, {{32{imm[19]}}, imm, 12'b0});
  endtask

  task automatic store_dw(int rs2, int rs1, logic [11:0] off);
    data_t a;
    a = xr[rs1] + sext12(off);
    place({off[11:5], 5'(rs2), 5'(rs1), 3'b011, off[4:0], OPC_STORE});
    ref_mem[a] = xr[rs2];
    exp_addr_q.push_back(a);
    exp_data_q.push_back(xr[rs2]);
  endtask

  task automatic poison_store(int rs2);
    place({poison_addr[11:5], 5'(rs2), 5'd0, 3'b011, poison_addr[4:0], OPC_STORE});
  endtask

  task automatic load_dw(int rd, int rs1, logic [11:0] off);
    place({off, 5'(rs1), 3'b011, 5'(rd), OPC_LOAD});
    set_reg(rd, ref_mem[xr[rs1] + sext12(off)]);
  endtask

  // taken skips two poison stores, not taken runs one real store
  task automatic branch_case(logic ne, int rs1, int rs2, logic [11:0] addr);
    logic        taken;
    logic [12:0] off;
    taken = ne ? (xr[rs1] != xr[rs2]) : (xr[rs1] == xr[rs2]);
    off   = taken ? 13'd12 : 13'd8;
    place({off[12], off[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, off[4:1], off[11], OPC_BRANCH});
    if (taken) begin
      poison_store(rs1);
      poison_store(rs2);
    end else begin
      store_dw(rs1, 0, addr);
    end
  endtask

  task automatic jump_link(int rd, logic [11:0] addr);
    logic [20:0] off;
    off = 21'd12;
    set_reg(rd, data_t'(slot * 4 + 4));   // link is own address plus 4
    place({off[20], off[10:1], off[11], off[19:12], 5'(rd), OPC_JAL});
    poison_store(0);
    poison_store(rd);
    store_dw(rd, 0, addr);
  endtask

  always @(negedge clk) begin
    data_t ea;
    data_t ed;
    if (rst_n && dmem_we) begin
      stores++;
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("store at %0t to address %h was not in the program", $time, dmem_addr);
      end else begin
        ea = exp_addr_q.pop_front();
        ed = exp_data_q.pop_front();
        addr_ok: assert (dmem_addr == ea) else begin
          errors++;
          $display("Fail %0t o_dmem_addr got %h expected %h", $time, dmem_addr, ea);
        end
        data_ok: assert (dmem_wdata == ed) else begin
          errors++;
          $display("Fail %0t o_dmem_wdata got %h expected %h", $time, dmem_wdata, ed);
        end
        if (ea == marker_addr) begin
          done = 1'b1;
        end
      end
    end
  end

  initial begin
    clk    = 1'b0;
    rst_n  = 1'b0;
    done   = 1'b0;
    errors = 0;
    stores = 0;
    slot   = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, OPC_OPIMM};   // addi x0, x0, i
      dmem[i] = data_t'(i) * 64'h9e37_79b9_7f4a_7c15;
    end
    for (int i = 0; i < 32; i++) begin
      xr[i] = '0;
    end
    // x1 comes from writeback and x2 from the memory stage
    for (int i = 0; i < 10; i++) begin
      add_imm(1, 1, 12'(rand_bits(12)));
      add_imm(2, 0, 12'(rand_bits(12)));
      alu_rr(i % 5, 3, 1, 2);
      alu_rr((i + 2) % 5, 4, 3, 1);
      store_dw(4, 0, 12'h100 + 12'(i * 8));
    end
    load_upper(5, 20'(rand_bits(20)));
    alu_rr(4, 6, 5, 3);
    store_dw(6, 0, 12'h180);
    store_dw(6, 0, 12'h188);
    load_dw(7, 0, 12'h188);
    alu_rr(0, 8, 7, 4);                  // load-use
    store_dw(8, 0, 12'h190);
    add_imm(9, 1, 12'h001);
    add_imm(11, 1, 12'h000);
    branch_case(1'b0, 1, 11, 12'h198);   // beq taken
    branch_case(1'b1, 1, 9, 12'h1a0);    // bne taken
    branch_case(1'b0, 1, 9, 12'h1a8);
    branch_case(1'b1, 1, 11, 12'h1b0);
    jump_link(10, 12'h1b8);
    add_imm(0, 10, 12'h5a5);             // x0 write is dropped
    store_dw(0, 0, 12'h1c0);
    store_dw(10, 0, marker_addr[11:0]);
    place({20'h0, 5'd0, OPC_JAL});       // jal x0, 0 parks the core

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    cycles = 0;
    while (!done && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      errors++;
      $display("no store to the marker address within %0d cycles", cycles);
    end
    repeat (4) @(posedge clk);           // stray stores would show here
    if (exp_addr_q.size() != 0) begin
      errors++;
      $display("%0d expected stores never reached the data port", exp_addr_q.size());
    end
    $display("stores %0d, check errors %0d, assertion errors %0d", stores, errors,
             i_riscv_core.u_riscv_core_properties.fail_cnt);
    if (errors == 0 && i_riscv_core.u_riscv_core_properties.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
